// File: design/amigaBusPkg.sv
// Amiga bus glue shared definitions: address map, timing, vector types and structs
`default_nettype none

package amigaBusPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    // CPU address, A31 down to A1
    typedef logic [31:1] addr_t;
    // 68040 transfer type and modifier
    typedef logic [1:0] tt_t;
    typedef logic [1:0] tm_t;
    // CIA clock divider count
    typedef logic [5:0] ciaCount_t;
    // ROM and autovector wait counter
    typedef logic [2:0] waitCount_t;

    // Transfer type and modifier codes
    localparam tt_t ttNormal = 2'd0;
    localparam tt_t ttCpuSpace = 2'd3;
    // Interrupt acknowledge when paired with CPU space
    localparam tm_t tmIntAck = 2'd1;

    ////////////////////////////////////////////////////////////////////////////
    // Address map, 24 bit space only
    ////////////////////////////////////////////////////////////////////////////

    // Kickstart ROM at the top of the map
    localparam logic [23:0] romBase = 24'hF8_0000;
    localparam logic [23:0] romMask = 24'hF8_0000;
    // Boot overlay maps ROM over low memory
    localparam logic [23:0] overlayLimit = 24'h07_FFFF;
    localparam logic [23:0] chipRamLimit = 24'h1F_FFFF;
    // CIA page, A23..A16
    localparam logic [7:0] ciaBase = 8'hBF;
    // Custom chip registers, A23..A12
    localparam logic [11:0] regBase = 12'hDFF;

    // Bus timing in clk40 cycles
    localparam waitCount_t romWaitCycles = 3'd4;
    localparam waitCount_t autovectorWaitCycles = 3'd1;
    localparam ciaCount_t ciaPeriod = 6'd40;
    // High phase sits at the end of the period
    localparam ciaCount_t ciaHighCycles = 6'd16;

    ////////////////////////////////////////////////////////////////////////////
    // Decode and acknowledge bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic romSel;
        logic ciaSel;
        logic ciaCs0;
        logic ciaCs1;
        logic ramSel;
        logic regSel;
        logic autovector;
    } spaceSel_t;

    // Open drain TACK split into value and drive enable
    typedef struct packed {
        logic tackN;
        logic tackDrive;
    } busAck_t;

    typedef enum logic [2:0] {
        ackIdle,
        ackRomWait,
        ackCiaWait,
        ackAssert,
        ackNegate
    } ackState_t;

endpackage

`default_nettype wire

// File: design/addressDecode.sv
// Address decode: CPU address and transfer type to ROM, RAM, register and CIA selects
`timescale 1ns/1ps
`default_nettype none

module addressDecode
    import amigaBusPkg::*;
(
    input  addr_t     a,
    input  tt_t       tt,
    input  tm_t       tm,
    input  logic      ovl,
    input  logic      ciaEnable,
    output spaceSel_t sel,
    output logic      ramSpaceN,
    output logic      regSpaceN,
    output logic      ciaCs0N,
    output logic      ciaCs1N,
    output logic      portSize,
    output logic      bufEnN
);

    ////////////////////////////////////////////////////////////////////////////
    // Address qualification
    ////////////////////////////////////////////////////////////////////////////

    // Byte address, A0 implied zero
    logic [31:0] byteAddr;
    // Only the low 16 MB is decoded here
    logic        lowSpace;
    logic        normalCycle;
    logic        intAckCycle;

    // Raw range hits before overlay priority
    logic        romRange;
    logic        overlayRange;
    logic        chipRange;
    logic        ciaPage;
    logic        regPage;

    assign byteAddr = {a, 1'b0};
    assign lowSpace = (byteAddr[31:24] == 8'h00);

    // Plain data or code access
    assign normalCycle = (tt == ttNormal);
    // IACK cycle in CPU space, answered with an autovector
    assign intAckCycle = (tt == ttCpuSpace) && (tm == tmIntAck);

    assign romRange = lowSpace && ((byteAddr[23:0] & romMask) == romBase);
    assign overlayRange = lowSpace && (byteAddr[23:0] <= overlayLimit);
    assign chipRange = lowSpace && (byteAddr[23:0] <= chipRamLimit);
    assign ciaPage = lowSpace && (byteAddr[23:16] == ciaBase);
    assign regPage = lowSpace && (byteAddr[23:12] == regBase);

    ////////////////////////////////////////////////////////////////////////////
    // Space selects
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sel = '0;

        if (normalCycle) begin
            // Overlay wins over chip RAM at boot
            sel.romSel = romRange || (ovl && overlayRange);
            sel.ramSel = chipRange && !(ovl && overlayRange);
            sel.regSel = regPage;
            sel.ciaSel = ciaPage;

            // CIA-A on A12 low, CIA-B on A13 low
            // Both only inside the E clock window
            sel.ciaCs0 = ciaPage && !byteAddr[12] && ciaEnable;
            sel.ciaCs1 = ciaPage && !byteAddr[13] && ciaEnable;
        end

        sel.autovector = intAckCycle;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Board strobes
    ////////////////////////////////////////////////////////////////////////////

    // Chipset space is handled by Agnus
    assign ramSpaceN = !sel.ramSel;
    assign regSpaceN = !sel.regSel;

    assign ciaCs0N = !sel.ciaCs0;
    assign ciaCs1N = !sel.ciaCs1;

    // 8 bit CIA and 16 bit registers need dynamic sizing
    assign portSize = sel.ciaSel || sel.regSel;

    // Data buffers open toward the chipset bus
    assign bufEnN = !(sel.ramSel || sel.regSel);

endmodule

`default_nettype wire

// File: design/ciaClock.sv
// CIA clock: divides clk40 into the E clock and opens the CIA access window
`timescale 1ns/1ps
`default_nettype none

module ciaClock
    import amigaBusPkg::*;
(
    input  logic clk40,
    input  logic rstN,
    input  logic ciaRequest,
    output logic ciaClk,
    output logic ciaEnable
);

    ////////////////////////////////////////////////////////////////////////////
    // Divider
    ////////////////////////////////////////////////////////////////////////////

    ciaCount_t count;
    ciaCount_t nextCount;
    logic      nextHigh;

    // Free running, wraps once per E period
    always_comb begin
        if (count == ciaPeriod - ciaCount_t'(1)) begin
            nextCount = '0;
        end else begin
            nextCount = count + ciaCount_t'(1);
        end
    end

    // High for the last part of the period
    assign nextHigh = (nextCount >= (ciaPeriod - ciaHighCycles));

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            ciaClk <= 1'b0;
        end else begin
            count <= nextCount;
            // Registered so the E clock leaves the chip glitch free
            ciaClk <= nextHigh;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Access window
    ////////////////////////////////////////////////////////////////////////////

    // Chip selects stay quiet unless a CIA cycle waits
    assign ciaEnable = ciaClk && ciaRequest;

endmodule

`default_nettype wire

// File: design/transferAck.sv
// Transfer acknowledge: times and drives TACK for ROM, autovector and CIA cycles
`timescale 1ns/1ps
`default_nettype none

module transferAck
    import amigaBusPkg::*;
(
    input  logic      clk40,
    input  logic      rstN,
    input  logic      tsN,
    input  spaceSel_t sel,
    input  logic      ciaClk,
    output busAck_t   ack,
    output logic      romEnN,
    output logic      ciaRequest
);

    ackState_t  state;
    // Remaining wait for ROM or autovector
    waitCount_t waitCnt;
    // Current cycle targets ROM, gates ROMEN
    logic       romCycle;
    // Last E clock level, for falling edge detect
    logic       ciaClkQ;
    logic       ciaFall;

    assign ciaFall = ciaClkQ && !ciaClk;

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            ciaClkQ <= 1'b0;
        end else begin
            ciaClkQ <= ciaClk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Acknowledge FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            state <= ackIdle;
            waitCnt <= '0;
            romCycle <= 1'b0;
            ciaRequest <= 1'b0;
            romEnN <= 1'b1;
            ack.tackN <= 1'b1;
            ack.tackDrive <= 1'b0;
        end else begin
            case (state)
                ackIdle: begin
                    // Chipset and unmapped cycles fall through, someone else acks
                    if (!tsN) begin
                        if (sel.romSel) begin
                            state <= ackRomWait;
                            romCycle <= 1'b1;
                            waitCnt <= romWaitCycles - waitCount_t'(1);
                        end else if (sel.autovector) begin
                            state <= ackRomWait;
                            romCycle <= 1'b0;
                            waitCnt <= autovectorWaitCycles - waitCount_t'(1);
                        end else if (sel.ciaSel) begin
                            state <= ackCiaWait;
                        end
                    end
                end

                ackRomWait: begin
                    // ROM output enable only for real ROM reads
                    romEnN <= !romCycle;
                    if (waitCnt == '0) begin
                        state <= ackAssert;
                        ack.tackN <= 1'b0;
                        ack.tackDrive <= 1'b1;
                    end else begin
                        waitCnt <= waitCnt - waitCount_t'(1);
                    end
                end

                ackCiaWait: begin
                    // Raise the request in a low phase, so the window is whole
                    if (!ciaRequest) begin
                        if (!ciaClk) begin
                            ciaRequest <= 1'b1;
                        end
                    end else if (ciaFall) begin
                        // E clock just ended the CIA access
                        ciaRequest <= 1'b0;
                        state <= ackAssert;
                        ack.tackN <= 1'b0;
                        ack.tackDrive <= 1'b1;
                    end
                end

                ackAssert: begin
                    // Drive TACK high for one cycle before letting go
                    state <= ackNegate;
                    ack.tackN <= 1'b1;
                    romEnN <= 1'b1;
                    romCycle <= 1'b0;
                end

                ackNegate: begin
                    state <= ackIdle;
                    ack.tackDrive <= 1'b0;
                end

                default: begin
                    state <= ackIdle;
                    ciaRequest <= 1'b0;
                    romEnN <= 1'b1;
                    ack.tackN <= 1'b1;
                    ack.tackDrive <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/busGlueTop.sv
// Bus glue top: joins address decode, CIA clock and transfer acknowledge
`timescale 1ns/1ps
`default_nettype none

module busGlueTop
    import amigaBusPkg::*;
(
    input  logic    clk40,
    input  logic    rstN,
    input  logic    tsN,
    input  logic    ovl,
    input  addr_t   a,
    input  tt_t     tt,
    input  tm_t     tm,
    output logic    romEnN,
    output logic    bufEnN,
    output logic    ciaClk,
    output logic    ciaCs0N,
    output logic    ciaCs1N,
    output logic    ramSpaceN,
    output logic    regSpaceN,
    output logic    portSize,
    output busAck_t ack
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////////////////////

    spaceSel_t sel;
    // E clock window, qualified by a waiting CIA cycle
    logic      ciaEnable;
    logic      ciaRequest;

    // Decode is purely combinational
    addressDecode uAddressDecode (
        .a         (a),
        .tt        (tt),
        .tm        (tm),
        .ovl       (ovl),
        .ciaEnable (ciaEnable),
        .sel       (sel),
        .ramSpaceN (ramSpaceN),
        .regSpaceN (regSpaceN),
        .ciaCs0N   (ciaCs0N),
        .ciaCs1N   (ciaCs1N),
        .portSize  (portSize),
        .bufEnN    (bufEnN)
    );

    ciaClock uCiaClock (
        .clk40      (clk40),
        .rstN       (rstN),
        .ciaRequest (ciaRequest),
        .ciaClk     (ciaClk),
        .ciaEnable  (ciaEnable)
    );

    // TACK value and drive enable, combined on the board
    transferAck uTransferAck (
        .clk40      (clk40),
        .rstN       (rstN),
        .tsN        (tsN),
        .sel        (sel),
        .ciaClk     (ciaClk),
        .ack        (ack),
        .romEnN     (romEnN),
        .ciaRequest (ciaRequest)
    );

endmodule

`default_nettype wire

// File: tests/busGlueTb.sv
// Bus glue testbench: address table and random sweep against decode and TACK timing
`timescale 1ns/1ps
`default_nettype none

module busGlueTb
    import amigaBusPkg::*;
();

    ////////////////////////////////////////////////////////////////////////////
    // Run limits and table types
    ////////////////////////////////////////////////////////////////////////////

    localparam int clkPeriod = 100;
    localparam int numTable = 16;
    localparam int numRandom = 32;
    // Longest CIA wait is well under two E periods
    localparam int waitBound = 2 * int'(ciaPeriod) + 8;
    localparam int watchdogCycles = (numTable + numRandom) * (2 * int'(ciaPeriod) + 12);
    // A23..A16 candidates for random rows, one per byte
    localparam logic [63:0] randomPages = 64'h00_07_1F_BF_DF_F8_FF_40;

    typedef enum logic [1:0] {kindNone, kindRom, kindAuto, kindCia} kind_t;

    // Strobe fields hold expected levels
    typedef struct packed {
        addr_t addr;
        tt_t   tt;
        tm_t   tm;
        logic  ovl;
        kind_t kind;
        logic  ramSpaceN;
        logic  regSpaceN;
        logic  portSize;
        logic  bufEnN;
    } vector_t;

    logic    clk40 = 1'b0;
    logic    rstN;
    logic    tsN;
    logic    ovl;
    addr_t   a;
    tt_t     tt;
    tm_t     tm;
    logic    romEnN;
    logic    bufEnN;
    logic    ciaClk;
    logic    ciaCs0N;
    logic    ciaCs1N;
    logic    ramSpaceN;
    logic    regSpaceN;
    logic    portSize;
    busAck_t ack;

    vector_t     vectors[$];
    string       names[$];
    logic [31:0] lfsrState = 32'heb737ba7;
    int          checkCount = 0;
    int          errorCount = 0;

    always #(clkPeriod / 2) clk40 = ~clk40;

    busGlueTop uut (
        .clk40     (clk40),
        .rstN      (rstN),
        .tsN       (tsN),
        .ovl       (ovl),
        .a         (a),
        .tt        (tt),
        .tm        (tm),
        .romEnN    (romEnN),
        .bufEnN    (bufEnN),
        .ciaClk    (ciaClk),
        .ciaCs0N   (ciaCs0N),
        .ciaCs1N   (ciaCs1N),
        .ramSpaceN (ramSpaceN),
        .regSpaceN (regSpaceN),
        .portSize  (portSize),
        .ack       (ack)
    );

    // Hard stop if a wait never ends
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("ERROR watchdog expired after %0d cycles, run stopped", watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic compareBit(input string testName, input string what, input logic expected,
            input logic actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("ERROR %s %s: expected %0b actual %0b", testName, what, expected, actual);
        end
    endtask

    task automatic matchCount(input string testName, input string what, input int expected,
            input int actual);
        checkCount++;
        assert (actual == expected) else begin
            errorCount++;
            $display("ERROR %s %s: expected %0d actual %0d", testName, what, expected, actual);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic drawBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
    endtask

    // Expected decode straight from the 24 bit memory map
    function automatic vector_t decodeModel(input logic [31:0] byteAddr, input tt_t ttIn,
            input tm_t tmIn, input logic ovlIn);
        vector_t v;
        logic    normal;
        logic    overlaid;
        logic    romHit;
        logic    ramHit;
        logic    regHit;
        logic    ciaHit;
        normal = (ttIn == ttNormal) && (byteAddr[31:24] == 8'h00);
        overlaid = ovlIn && (byteAddr[23:0] <= overlayLimit);
        romHit = normal && ((byteAddr[23:0] >= romBase) || overlaid);
        ramHit = normal && (byteAddr[23:0] <= chipRamLimit) && !overlaid;
        regHit = normal && (byteAddr[23:12] == regBase);
        ciaHit = normal && (byteAddr[23:16] == ciaBase);
        v.addr = byteAddr[31:1];
        v.tt = ttIn;
        v.tm = tmIn;
        v.ovl = ovlIn;
        if (romHit) begin
            v.kind = kindRom;
        end else if (ttIn == ttCpuSpace && tmIn == tmIntAck) begin
            v.kind = kindAuto;
        end else begin
            v.kind = ciaHit ? kindCia : kindNone;
        end
        v.ramSpaceN = !ramHit;
        v.regSpaceN = !regHit;
        v.portSize = ciaHit || regHit;
        v.bufEnN = !(ramHit || regHit);
        return v;
    endfunction

    // Strobes packed as ramSpaceN, regSpaceN, portSize, bufEnN
    task automatic addVector(input string name, input logic [31:0] byteAddr, input tt_t ttIn,
            input tm_t tmIn, input logic ovlIn, input kind_t kind, input logic [3:0] strobes);
        vectors.push_back({byteAddr[31:1], ttIn, tmIn, ovlIn, kind, strobes});
        names.push_back(name);
    endtask

    task automatic measureCiaClock();
        int highCount;
        int lowCount;
        highCount = 0;
        lowCount = 0;
        // Line up on a rising E clock
        @(negedge clk40);
        while (ciaClk) @(negedge clk40);
        while (!ciaClk) @(negedge clk40);
        while (ciaClk) begin
            highCount++;
            @(negedge clk40);
        end
        while (!ciaClk) begin
            lowCount++;
            @(negedge clk40);
        end
        matchCount("ciaClock", "high cycles", int'(ciaHighCycles), highCount);
        matchCount("ciaClock", "period", int'(ciaPeriod), highCount + lowCount);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One bus cycle
    ////////////////////////////////////////////////////////////////////////////

    task automatic runVector(input vector_t v, input string name);
        int   k;
        int   expectAt;
        int   ackAt;
        int   phase;
        logic acked;
        logic windowOpen;
        k = 0;
        ackAt = -1;
        phase = 0;
        acked = 1'b0;
        expectAt = -1;
        if (v.kind == kindRom) begin
            expectAt = int'(romWaitCycles);
        end else if (v.kind == kindAuto) begin
            expectAt = int'(autovectorWaitCycles);
        end
        @(negedge clk40);
        a = v.addr;
        tt = v.tt;
        tm = v.tm;
        ovl = v.ovl;
        tsN = 1'b0;
        // Sample edge, cycle 0
        @(posedge clk40);
        while (!acked && k < waitBound) begin
            @(negedge clk40);
            // Stray start inside the wait, the FSM must ignore it
            tsN = (k == 1) ? 1'b0 : 1'b1;
            if (k == 0) begin
                compareBit(name, "ramSpaceN", v.ramSpaceN, ramSpaceN);
                compareBit(name, "regSpaceN", v.regSpaceN, regSpaceN);
                compareBit(name, "portSize", v.portSize, portSize);
                compareBit(name, "bufEnN", v.bufEnN, bufEnN);
            end
            // CIA waits for a low phase, then a whole high phase, then the fall
            if (v.kind == kindCia) begin
                if (phase == 0 && !ciaClk) begin
                    phase = 1;
                end else if (phase == 1 && ciaClk) begin
                    phase = 2;
                end else if (phase == 2 && !ciaClk) begin
                    phase = 3;
                    expectAt = k + 1;
                end
            end
            windowOpen = (phase == 2) && ciaClk;
            compareBit(name, "ciaCs0N", !(windowOpen && !v.addr[12]), ciaCs0N);
            compareBit(name, "ciaCs1N", !(windowOpen && !v.addr[13]), ciaCs1N);
            compareBit(name, "romEnN", !(v.kind == kindRom && k >= 1 && k <= expectAt), romEnN);
            compareBit(name, "tackDrive", k == expectAt, ack.tackDrive);
            if (ack.tackDrive && !ack.tackN) begin
                acked = 1'b1;
                ackAt = k;
            end else begin
                k++;
            end
        end
        if (acked) begin
            matchCount(name, "ack cycle", expectAt, ackAt);
            @(negedge clk40);
            tsN = 1'b1;
            // One driven high cycle, then release
            compareBit(name, "tackN negate", 1'b1, ack.tackN);
            compareBit(name, "tackDrive negate", 1'b1, ack.tackDrive);
            compareBit(name, "romEnN negate", 1'b1, romEnN);
            @(negedge clk40);
            compareBit(name, "tackDrive release", 1'b0, ack.tackDrive);
        end else begin
            checkCount++;
            assert (v.kind == kindNone) else begin
                errorCount++;
                $display("ERROR %s: no transfer acknowledge within %0d cycles", name, waitBound);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] bits;
        logic [31:0] byteAddr;
        rstN = 1'b0;
        tsN = 1'b1;
        ovl = 1'b0;
        a = '0;
        tt = ttNormal;
        tm = '0;

        addVector("romLow", 32'h00F8_0000, ttNormal, 2'd0, 1'b0, kindRom, 4'b1101);
        addVector("romHigh", 32'h00FF_FFFE, ttNormal, 2'd0, 1'b0, kindRom, 4'b1101);
        addVector("overlayBoot", 32'h0000_0100, ttNormal, 2'd0, 1'b1, kindRom, 4'b1101);
        addVector("overlayEdge", 32'h0007_FFFE, ttNormal, 2'd0, 1'b1, kindRom, 4'b1101);
        addVector("chipRam", 32'h0000_0100, ttNormal, 2'd0, 1'b0, kindNone, 4'b0100);
        addVector("chipAboveOverlay", 32'h0008_0000, ttNormal, 2'd0, 1'b1, kindNone, 4'b0100);
        addVector("chipTop", 32'h001F_FFFE, ttNormal, 2'd0, 1'b0, kindNone, 4'b0100);
        addVector("customReg", 32'h00DF_F180, ttNormal, 2'd0, 1'b0, kindNone, 4'b1010);
        addVector("ciaA", 32'h00BF_E000, ttNormal, 2'd0, 1'b0, kindCia, 4'b1111);
        addVector("ciaB", 32'h00BF_D000, ttNormal, 2'd0, 1'b0, kindCia, 4'b1111);
        addVector("ciaBoth", 32'h00BF_C000, ttNormal, 2'd0, 1'b0, kindCia, 4'b1111);
        addVector("intAck", 32'h00FF_FFF0, ttCpuSpace, tmIntAck, 1'b0, kindAuto, 4'b1101);
        addVector("intAckBitsNormal", 32'h00FF_FFF0, ttNormal, 2'd0, 1'b0, kindRom, 4'b1101);
        addVector("cpuSpaceOther", 32'h00FF_FFF0, ttCpuSpace, 2'd2, 1'b0, kindNone, 4'b1101);
        addVector("unmapped", 32'h0040_0000, ttNormal, 2'd0, 1'b0, kindNone, 4'b1101);
        addVector("highUnmapped", 32'h01F8_0000, ttNormal, 2'd0, 1'b0, kindNone, 4'b1101);

        // Random rows, page from a short list, low word and ovl from the LFSR
        for (int i = 0; i < numRandom; i++) begin
            drawBits(3, bits);
            byteAddr[31:16] = {8'h00, randomPages[int'(bits[2:0]) * 8 +: 8]};
            drawBits(15, bits);
            byteAddr[15:0] = {bits[14:0], 1'b0};
            drawBits(1, bits);
            vectors.push_back(decodeModel(byteAddr, ttNormal, 2'd0, bits[0]));
            names.push_back($sformatf("random%0d", i));
        end

        repeat (2) @(negedge clk40);
        compareBit("reset", "tackDrive", 1'b0, ack.tackDrive);
        compareBit("reset", "tackN", 1'b1, ack.tackN);
        compareBit("reset", "romEnN", 1'b1, romEnN);
        compareBit("reset", "ciaClk", 1'b0, ciaClk);
        rstN = 1'b1;

        measureCiaClock();
        for (int i = 0; i < vectors.size(); i++) begin
            runVector(vectors[i], names[i]);
        end

        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
design/amigaBusPkg.sv
design/addressDecode.sv
design/ciaClock.sv
design/transferAck.sv
design/busGlueTop.sv
tests/busGlueTb.sv

// File: run.sh
#!/bin/sh
# Build and run the bus glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module busGlueTb -Mdir obj_dir -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/VbusGlueTb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$log"; then
    exit 0
fi
echo "Pass line not found in $log"
exit 1
